// File: verilog/fe_pkg.sv
// Fetch front end shared definitions
// Address widths, predictor table geometry, credits and branch kinds
`default_nettype none

package fe_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Address space
  ////////////////////////////////////////////////////////////////////////////
  localparam int VADDR_W = 32;

  // First fetch after reset
  localparam logic [VADDR_W-1:0] RESET_PC = 32'h8000_0000;

  ////////////////////////////////////////////////////////////////////////////
  // Predictor tables
  ////////////////////////////////////////////////////////////////////////////
  // BTB index is PC[5:2], tag is PC[31:6]
  localparam int BTB_IDX_W = 4;
  localparam int BTB_TAG_W = 26;

  // 64 counters, index hashed with global history
  localparam int BHT_IDX_W = 6;
  localparam int GHIST_W   = 6;

  localparam int RAS_DEPTH = 8;
  localparam int RAS_PTR_W = 3;

  ////////////////////////////////////////////////////////////////////////////
  // Fetch flow control
  ////////////////////////////////////////////////////////////////////////////
  localparam int FETCH_CREDITS = 4;
  // Must hold 0 to FETCH_CREDITS
  localparam int CREDIT_W      = 3;

  // Control-flow kind recorded in the BTB
  typedef enum logic [1:0] {
    KIND_BR   = 2'd0,
    KIND_JAL  = 2'd1,
    KIND_CALL = 2'd2,
    KIND_RET  = 2'd3
  } branch_kind_e;

endpackage

`default_nettype wire

// File: verilog/fe_update_if.sv
// Committed branch outcome bus from the PC generator to the predictor tables
// No handshake, an update is taken in any cycle with v high
`default_nettype none

interface fe_update_if;

  logic                              v;
  logic [fe_pkg::VADDR_W-1:0]        pc;
  logic [fe_pkg::VADDR_W-1:0]        tgt;
  fe_pkg::branch_kind_e              kind;
  logic                              taken;
  // Global history seen by this branch at commit
  logic [fe_pkg::GHIST_W-1:0]        hist;

  modport src (
    output v,
    output pc,
    output tgt,
    output kind,
    output taken,
    output hist
  );

  modport dst (
    input v,
    input pc,
    input tgt,
    input kind,
    input taken,
    input hist
  );

endinterface

`default_nettype wire

// File: verilog/fe_btb.sv
// Direct-mapped branch target buffer
// Combinational lookup, written from committed taken branches and jumps
`default_nettype none

module fe_btb
  (input  wire                             clk_i
   , input  wire                           arst_n_i

   , input  wire [fe_pkg::VADDR_W-1:0]     lookup_pc_i
   , output logic                          hit_o
   , output fe_pkg::branch_kind_e          kind_o
   , output logic [fe_pkg::VADDR_W-1:0]    tgt_o

   , fe_update_if.dst                      upd
   );

  localparam int ENTRIES = 1 << fe_pkg::BTB_IDX_W;
  localparam int IDX_LO  = 2;
  localparam int TAG_LO  = fe_pkg::BTB_IDX_W + 2;

  logic                           valid_r [ENTRIES];
  logic [fe_pkg::BTB_TAG_W-1:0]   tag_q   [ENTRIES];
  logic [fe_pkg::VADDR_W-1:0]     tgt_q   [ENTRIES];
  fe_pkg::branch_kind_e           kind_q  [ENTRIES];

  logic [fe_pkg::BTB_IDX_W-1:0]   rd_idx;
  logic [fe_pkg::BTB_TAG_W-1:0]   rd_tag;
  logic [fe_pkg::BTB_IDX_W-1:0]   wr_idx;
  logic [fe_pkg::BTB_TAG_W-1:0]   wr_tag;
  logic                           wr_en;

  ////////////////////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////////////////////
  assign rd_idx = lookup_pc_i[TAG_LO-1:IDX_LO];
  assign rd_tag = lookup_pc_i[fe_pkg::VADDR_W-1:TAG_LO];

  assign hit_o  = valid_r[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign kind_o = kind_q[rd_idx];
  assign tgt_o  = tgt_q[rd_idx];

  ////////////////////////////////////////////////////////////////////////////
  // Training
  ////////////////////////////////////////////////////////////////////////////
  // Not-taken conditional branches never allocate
  assign wr_en  = upd.v && (upd.taken || (upd.kind != fe_pkg::KIND_BR));
  assign wr_idx = upd.pc[TAG_LO-1:IDX_LO];
  assign wr_tag = upd.pc[fe_pkg::VADDR_W-1:TAG_LO];

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 0; i < ENTRIES; i++)
      begin
        valid_r[i] <= 1'b0;
      end
    end
    else if (wr_en)
    begin
      valid_r[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      tag_q[wr_idx]  <= wr_tag;
      tgt_q[wr_idx]  <= upd.tgt;
      kind_q[wr_idx] <= upd.kind;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fe_bht.sv
// Branch history table of 2-bit saturating counters
// Indexed by PC[7:2] xor global history, trained on committed branches
`default_nettype none

module fe_bht
  (input  wire                             clk_i
   , input  wire                           arst_n_i

   , input  wire [fe_pkg::VADDR_W-1:0]     lookup_pc_i
   , input  wire [fe_pkg::GHIST_W-1:0]     hist_i
   , output logic                          taken_o

   , fe_update_if.dst                      upd
   );

  localparam int ENTRIES = 1 << fe_pkg::BHT_IDX_W;
  localparam int IDX_HI  = fe_pkg::BHT_IDX_W + 1;

  // Weakly not taken
  localparam logic [1:0] CTR_INIT = 2'b01;

  logic [1:0]                     ctr_r [ENTRIES];
  logic [fe_pkg::BHT_IDX_W-1:0]   rd_idx;
  logic [fe_pkg::BHT_IDX_W-1:0]   wr_idx;
  logic                           wr_en;
  logic [1:0]                     wr_ctr;

  // Upper counter bit is the prediction
  assign rd_idx  = lookup_pc_i[IDX_HI:2] ^ hist_i;
  assign taken_o = ctr_r[rd_idx][1];

  ////////////////////////////////////////////////////////////////////////////
  // Commit-time training
  ////////////////////////////////////////////////////////////////////////////
  assign wr_en  = upd.v && (upd.kind == fe_pkg::KIND_BR);
  assign wr_idx = upd.pc[IDX_HI:2] ^ upd.hist;

  always_comb
  begin
    wr_ctr = ctr_r[wr_idx];
    if (upd.taken && (ctr_r[wr_idx] != 2'b11))
    begin
      wr_ctr = ctr_r[wr_idx] + 2'b01;
    end
    else if (!upd.taken && (ctr_r[wr_idx] != 2'b00))
    begin
      wr_ctr = ctr_r[wr_idx] - 2'b01;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 0; i < ENTRIES; i++)
      begin
        ctr_r[i] <= CTR_INIT;
      end
    end
    else if (wr_en)
    begin
      ctr_r[wr_idx] <= wr_ctr;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fe_ras.sv
// Circular return address stack
// Overflow drops the oldest entry, a pop on empty does nothing
`default_nettype none

module fe_ras
  (input  wire                             clk_i
   , input  wire                           arst_n_i

   , input  wire                           push_i
   , input  wire                           pop_i
   , input  wire [fe_pkg::VADDR_W-1:0]     push_addr_i

   , output logic [fe_pkg::VADDR_W-1:0]    top_o
   , output logic                          empty_o
   );

  localparam int CNT_W = fe_pkg::RAS_PTR_W + 1;
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(fe_pkg::RAS_DEPTH);

  logic [fe_pkg::VADDR_W-1:0]     stack_q [fe_pkg::RAS_DEPTH];
  logic [fe_pkg::RAS_PTR_W-1:0]   top_r;
  logic [CNT_W-1:0]               cnt_r;
  logic [fe_pkg::RAS_PTR_W-1:0]   top_inc;

  assign top_inc = top_r + 1'b1;
  assign top_o   = stack_q[top_r];
  assign empty_o = (cnt_r == '0);

  // Pointer and occupancy; push wins if both arrive together
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      top_r <= '0;
      cnt_r <= '0;
    end
    else if (push_i)
    begin
      top_r <= top_inc;
      if (cnt_r != CNT_FULL)
      begin
        cnt_r <= cnt_r + 1'b1;
      end
    end
    else if (pop_i && !empty_o)
    begin
      top_r <= top_r - 1'b1;
      cnt_r <= cnt_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push_i)
    begin
      stack_q[top_inc] <= push_addr_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fe_pc_gen.sv
// Fetch PC generator with credit-based issue and global branch history
// Picks redirect, BTB/BHT/RAS prediction or PC+4 for the next fetch
`default_nettype none

module fe_pc_gen
  (input  wire                             clk_i
   , input  wire                           arst_n_i

   , input  wire                           redirect_v_i
   , input  wire [fe_pkg::VADDR_W-1:0]     redirect_pc_i

   , input  wire                           upd_v_i
   , input  wire [fe_pkg::VADDR_W-1:0]     upd_pc_i
   , input  wire [fe_pkg::VADDR_W-1:0]     upd_tgt_i
   , input  fe_pkg::branch_kind_e          upd_kind_i
   , input  wire                           upd_taken_i

   , input  wire                           credit_return_i
   , output logic                          fetch_v_o
   , output logic [fe_pkg::VADDR_W-1:0]    fetch_pc_o

   , fe_update_if.src                      upd

   , input  wire                           btb_hit_i
   , input  fe_pkg::branch_kind_e          btb_kind_i
   , input  wire [fe_pkg::VADDR_W-1:0]     btb_tgt_i
   , input  wire                           bht_taken_i

   , output logic                          ras_push_o
   , output logic                          ras_pop_o
   , output logic [fe_pkg::VADDR_W-1:0]    ras_push_addr_o
   , input  wire [fe_pkg::VADDR_W-1:0]     ras_top_i
   , input  wire                           ras_empty_i

   , output logic [fe_pkg::VADDR_W-1:0]    pc_o
   , output logic [fe_pkg::GHIST_W-1:0]    hist_o
   );

  logic [fe_pkg::VADDR_W-1:0]   pc_r;
  logic [fe_pkg::VADDR_W-1:0]   pc_n;
  logic [fe_pkg::VADDR_W-1:0]   pc_plus4;
  logic [fe_pkg::VADDR_W-1:0]   pred_pc;
  logic [fe_pkg::CREDIT_W-1:0]  credit_r;
  logic [fe_pkg::CREDIT_W-1:0]  credit_n;
  logic [fe_pkg::GHIST_W-1:0]   ghist_r;
  logic                         issue;
  logic                         pred_used;

  ////////////////////////////////////////////////////////////////////////////
  // Issue and credits
  ////////////////////////////////////////////////////////////////////////////
  assign fetch_v_o  = (credit_r != '0);
  assign issue      = fetch_v_o;
  assign fetch_pc_o = pc_r;

  always_comb
  begin
    credit_n = credit_r;
    if (issue && !credit_return_i)
    begin
      credit_n = credit_r - 1'b1;
    end
    else if (!issue && credit_return_i)
    begin
      credit_n = credit_r + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next PC
  ////////////////////////////////////////////////////////////////////////////
  assign pc_plus4 = pc_r + fe_pkg::VADDR_W'(4);

  always_comb
  begin
    pred_pc = pc_plus4;
    if (btb_hit_i)
    begin
      case (btb_kind_i)
        fe_pkg::KIND_JAL,
        fe_pkg::KIND_CALL: pred_pc = btb_tgt_i;
        fe_pkg::KIND_BR:   pred_pc = bht_taken_i ? btb_tgt_i : pc_plus4;
        fe_pkg::KIND_RET:  pred_pc = ras_empty_i ? pc_plus4 : ras_top_i;
        default:           pred_pc = pc_plus4;
      endcase
    end
  end

  // Redirect wins even with no credits; low PC bits are dropped
  always_comb
  begin
    if (redirect_v_i)
    begin
      pc_n = {redirect_pc_i[fe_pkg::VADDR_W-1:2], 2'b00};
    end
    else if (issue)
    begin
      pc_n = pred_pc;
    end
    else
    begin
      pc_n = pc_r;
    end
  end

  // A prediction overridden by redirect leaves the RAS untouched
  assign pred_used       = issue && !redirect_v_i && btb_hit_i;
  assign ras_push_o      = pred_used && (btb_kind_i == fe_pkg::KIND_CALL);
  assign ras_pop_o       = pred_used && (btb_kind_i == fe_pkg::KIND_RET) && !ras_empty_i;
  assign ras_push_addr_o = pc_plus4;

  assign pc_o   = pc_r;
  assign hist_o = ghist_r;

  ////////////////////////////////////////////////////////////////////////////
  // Commit forwarding
  ////////////////////////////////////////////////////////////////////////////
  assign upd.v     = upd_v_i;
  assign upd.pc    = upd_pc_i;
  // Word aligned so learned targets stay fetchable
  assign upd.tgt   = {upd_tgt_i[fe_pkg::VADDR_W-1:2], 2'b00};
  assign upd.kind  = upd_kind_i;
  assign upd.taken = upd_taken_i;
  assign upd.hist  = ghist_r;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      pc_r     <= fe_pkg::RESET_PC;
      credit_r <= fe_pkg::CREDIT_W'(fe_pkg::FETCH_CREDITS);
      ghist_r  <= '0;
    end
    else
    begin
      pc_r     <= pc_n;
      credit_r <= credit_n;
      // Only conditional branches shift history
      if (upd_v_i && (upd_kind_i == fe_pkg::KIND_BR))
      begin
        ghist_r <= {ghist_r[fe_pkg::GHIST_W-2:0], upd_taken_i};
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/fe_top.sv
// Instruction fetch front end top level
// PC generator with BTB, BHT and return address stack
`default_nettype none

module fe_top
  (input  wire                             clk_i
   , input  wire                           arst_n_i

   , input  wire                           redirect_v_i
   , input  wire [fe_pkg::VADDR_W-1:0]     redirect_pc_i

   , input  wire                           upd_v_i
   , input  wire [fe_pkg::VADDR_W-1:0]     upd_pc_i
   , input  wire [fe_pkg::VADDR_W-1:0]     upd_tgt_i
   , input  fe_pkg::branch_kind_e          upd_kind_i
   , input  wire                           upd_taken_i

   , input  wire                           credit_return_i
   , output logic                          fetch_v_o
   , output logic [fe_pkg::VADDR_W-1:0]    fetch_pc_o
   );

  fe_update_if upd_if ();

  logic                          btb_hit;
  fe_pkg::branch_kind_e          btb_kind;
  logic [fe_pkg::VADDR_W-1:0]    btb_tgt;
  logic                          bht_taken;
  logic                          ras_push;
  logic                          ras_pop;
  logic [fe_pkg::VADDR_W-1:0]    ras_push_addr;
  logic [fe_pkg::VADDR_W-1:0]    ras_top;
  logic                          ras_empty;
  logic [fe_pkg::VADDR_W-1:0]    lookup_pc;
  logic [fe_pkg::GHIST_W-1:0]    ghist;

  fe_pc_gen pc_gen_i
    (.clk_i            (clk_i)
     ,.arst_n_i        (arst_n_i)
     ,.redirect_v_i    (redirect_v_i)
     ,.redirect_pc_i   (redirect_pc_i)
     ,.upd_v_i         (upd_v_i)
     ,.upd_pc_i        (upd_pc_i)
     ,.upd_tgt_i       (upd_tgt_i)
     ,.upd_kind_i      (upd_kind_i)
     ,.upd_taken_i     (upd_taken_i)
     ,.credit_return_i (credit_return_i)
     ,.fetch_v_o       (fetch_v_o)
     ,.fetch_pc_o      (fetch_pc_o)
     ,.upd             (upd_if.src)
     ,.btb_hit_i       (btb_hit)
     ,.btb_kind_i      (btb_kind)
     ,.btb_tgt_i       (btb_tgt)
     ,.bht_taken_i     (bht_taken)
     ,.ras_push_o      (ras_push)
     ,.ras_pop_o       (ras_pop)
     ,.ras_push_addr_o (ras_push_addr)
     ,.ras_top_i       (ras_top)
     ,.ras_empty_i     (ras_empty)
     ,.pc_o            (lookup_pc)
     ,.hist_o          (ghist)
     );

  fe_btb btb_i
    (.clk_i        (clk_i)
     ,.arst_n_i    (arst_n_i)
     ,.lookup_pc_i (lookup_pc)
     ,.hit_o       (btb_hit)
     ,.kind_o      (btb_kind)
     ,.tgt_o       (btb_tgt)
     ,.upd         (upd_if.dst)
     );

  fe_bht bht_i
    (.clk_i        (clk_i)
     ,.arst_n_i    (arst_n_i)
     ,.lookup_pc_i (lookup_pc)
     ,.hist_i      (ghist)
     ,.taken_o     (bht_taken)
     ,.upd         (upd_if.dst)
     );

  fe_ras ras_i
    (.clk_i        (clk_i)
     ,.arst_n_i    (arst_n_i)
     ,.push_i      (ras_push)
     ,.pop_i       (ras_pop)
     ,.push_addr_i (ras_push_addr)
     ,.top_o       (ras_top)
     ,.empty_o     (ras_empty)
     );

endmodule

`default_nettype wire

// File: test/fe_assertions.sv
// Fetch PC generator checks on credits, issue and PC alignment
`default_nettype none

module fe_pc_assertions
  (input  wire                              clk_i
   , input  wire                            arst_n_i
   , input  wire [fe_pkg::CREDIT_W-1:0]     credit_i
   , input  wire                            credit_return_i
   , input  wire                            fetch_v_i
   , input  wire [fe_pkg::VADDR_W-1:0]      fetch_pc_i
   );

  localparam logic [fe_pkg::CREDIT_W-1:0] CREDIT_MAX =
    fe_pkg::CREDIT_W'(fe_pkg::FETCH_CREDITS);

  // Credits as the consumer sees them, from issues and returns only
  logic [fe_pkg::CREDIT_W-1:0] held_q;
  int                          fail_cnt = 0;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      held_q <= CREDIT_MAX;
    end
    else if (fetch_v_i && !credit_return_i)
    begin
      held_q <= held_q - 1'b1;
    end
    else if (!fetch_v_i && credit_return_i)
    begin
      held_q <= held_q + 1'b1;
    end
  end

  // Never more credits than granted at reset
  credit_bound_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) credit_i <= CREDIT_MAX
  ) else
  begin
    fail_cnt++;
    $error("Credit count went above the reset allowance");
  end

  credit_issue_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) fetch_v_i |-> (held_q != '0)
  ) else
  begin
    fail_cnt++;
    $error("Fetch issued while no credits were held");
  end

  // Instructions are 4 bytes
  pc_align_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) fetch_pc_i[1:0] == 2'b00
  ) else
  begin
    fail_cnt++;
    $error("Fetch PC is not word aligned");
  end

endmodule

bind fe_pc_gen fe_pc_assertions pc_assert_i
  (.clk_i            (clk_i)
   ,.arst_n_i        (arst_n_i)
   ,.credit_i        (credit_r)
   ,.credit_return_i (credit_return_i)
   ,.fetch_v_i       (fetch_v_o)
   ,.fetch_pc_i      (fetch_pc_o)
   );

`default_nettype wire

// File: test/fe_tb.sv
// Fetch front end testbench
// Reference predictor model checks every issued PC, directed and random stimulus
`default_nettype none

module fe_tb;

  localparam int          MAX_CYCLES = 2000;
  localparam logic [31:0] SEED       = 32'h33c0_309e;
  localparam logic [fe_pkg::CREDIT_W-1:0] CREDIT_MAX =
    fe_pkg::CREDIT_W'(fe_pkg::FETCH_CREDITS);

  logic                  clk_i;
  logic                  arst_n_i;
  logic                  redirect_v_i;
  logic [31:0]           redirect_pc_i;
  logic                  upd_v_i;
  logic [31:0]           upd_pc_i;
  logic [31:0]           upd_tgt_i;
  fe_pkg::branch_kind_e  upd_kind_i;
  logic                  upd_taken_i;
  logic                  credit_return_i;
  logic                  fetch_v_o;
  logic [31:0]           fetch_pc_o;

  // Reference state, one cycle ahead of the DUT after each falling edge
  logic [31:0]                  m_pc;
  logic [fe_pkg::CREDIT_W-1:0]  m_credits;
  logic [5:0]                   m_hist;
  logic                         m_btb_v    [16];
  logic [25:0]                  m_btb_tag  [16];
  logic [31:0]                  m_btb_tgt  [16];
  fe_pkg::branch_kind_e         m_btb_kind [16];
  logic [1:0]                   m_bht      [64];
  logic [31:0]                  m_ras      [8];
  logic [2:0]                   m_ras_top;
  int                           m_ras_cnt;

  logic [31:0]  lfsr_q;
  string        test_name;
  int           error_count;
  int           check_count;
  int           test_err_base;
  int           cycle_count;
  int           test_count;

  fe_top fe_top_i
    (.clk_i            (clk_i)
     ,.arst_n_i        (arst_n_i)
     ,.redirect_v_i    (redirect_v_i)
     ,.redirect_pc_i   (redirect_pc_i)
     ,.upd_v_i         (upd_v_i)
     ,.upd_pc_i        (upd_pc_i)
     ,.upd_tgt_i       (upd_tgt_i)
     ,.upd_kind_i      (upd_kind_i)
     ,.upd_taken_i     (upd_taken_i)
     ,.credit_return_i (credit_return_i)
     ,.fetch_v_o       (fetch_v_o)
     ,.fetch_pc_o      (fetch_pc_o)
     );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random bits
  ////////////////////////////////////////////////////////////////////////////
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] predict_next(input logic [31:0] pc);
    logic [3:0]  bi;
    logic [5:0]  hi;
    logic [31:0] nxt;
    bi  = pc[5:2];
    hi  = pc[7:2] ^ m_hist;
    nxt = pc + 32'd4;
    if (m_btb_v[bi] && (m_btb_tag[bi] == pc[31:6]))
    begin
      case (m_btb_kind[bi])
        fe_pkg::KIND_JAL,
        fe_pkg::KIND_CALL: nxt = m_btb_tgt[bi];
        fe_pkg::KIND_BR:   nxt = m_bht[hi][1] ? m_btb_tgt[bi] : nxt;
        default:           nxt = (m_ras_cnt != 0) ? m_ras[m_ras_top] : nxt;
      endcase
    end
    return nxt;
  endfunction

  task automatic reset_model();
    for (int i = 0; i < 16; i++)
    begin
      m_btb_v[i] = 1'b0;
    end
    for (int i = 0; i < 64; i++)
    begin
      m_bht[i] = 2'b01;
    end
    m_pc      = fe_pkg::RESET_PC;
    m_credits = CREDIT_MAX;
    m_hist    = '0;
    m_ras_top = '0;
    m_ras_cnt = 0;
  endtask

  // Apply one clock edge with the inputs currently driven
  task automatic advance_model(input logic issue);
    logic [3:0]  bi;
    logic [5:0]  ui;
    logic [3:0]  wi;
    logic        hit;
    logic [31:0] nxt;
    bi  = m_pc[5:2];
    hit = m_btb_v[bi] && (m_btb_tag[bi] == m_pc[31:6]);
    nxt = predict_next(m_pc);
    // Speculative RAS only for predictions that really steer fetch
    if (issue && !redirect_v_i && hit)
    begin
      if (m_btb_kind[bi] == fe_pkg::KIND_CALL)
      begin
        m_ras_top        = m_ras_top + 3'd1;
        m_ras[m_ras_top] = m_pc + 32'd4;
        m_ras_cnt        = (m_ras_cnt < 8) ? m_ras_cnt + 1 : m_ras_cnt;
      end
      else if ((m_btb_kind[bi] == fe_pkg::KIND_RET) && (m_ras_cnt != 0))
      begin
        m_ras_top = m_ras_top - 3'd1;
        m_ras_cnt = m_ras_cnt - 1;
      end
    end
    if (redirect_v_i)
    begin
      m_pc = {redirect_pc_i[31:2], 2'b00};
    end
    else if (issue)
    begin
      m_pc = nxt;
    end
    if (issue && !credit_return_i)
    begin
      m_credits = m_credits - 1'b1;
    end
    else if (!issue && credit_return_i)
    begin
      m_credits = m_credits + 1'b1;
    end
    if (upd_v_i)
    begin
      if (upd_kind_i == fe_pkg::KIND_BR)
      begin
        ui = upd_pc_i[7:2] ^ m_hist;
        if (upd_taken_i && (m_bht[ui] != 2'b11))
        begin
          m_bht[ui] = m_bht[ui] + 2'd1;
        end
        else if (!upd_taken_i && (m_bht[ui] != 2'b00))
        begin
          m_bht[ui] = m_bht[ui] - 2'd1;
        end
        m_hist = {m_hist[4:0], upd_taken_i};
      end
      if (upd_taken_i || (upd_kind_i != fe_pkg::KIND_BR))
      begin
        wi             = upd_pc_i[5:2];
        m_btb_v[wi]    = 1'b1;
        m_btb_tag[wi]  = upd_pc_i[31:6];
        m_btb_tgt[wi]  = {upd_tgt_i[31:2], 2'b00};
        m_btb_kind[wi] = upd_kind_i;
      end
    end
  endtask

  task automatic report_error(input string what, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    error_count++;
    $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
  endtask

  // Outputs are settled mid-cycle
  always @(negedge clk_i)
  begin : compare
    logic issue;
    if (!arst_n_i)
    begin
      reset_model();
    end
    else
    begin
      issue = (m_credits != '0);
      check_count++;
      assert (fetch_v_o == issue)
      else report_error("fetch_v_o", 32'(issue), 32'(fetch_v_o));
      if (issue)
      begin
        check_count++;
        assert (fetch_pc_o == m_pc)
        else report_error("fetch_pc_o", m_pc, fetch_pc_o);
      end
      advance_model(issue);
    end
  end

  always @(posedge clk_i)
  begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("Timeout: the run went past %0d cycles in test %s", MAX_CYCLES, test_name);
      $display("test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic send_update(input logic [31:0] pc, input logic [31:0] tgt,
                             input fe_pkg::branch_kind_e kind, input logic taken);
    @(posedge clk_i);
    upd_v_i     <= 1'b1;
    upd_pc_i    <= pc;
    upd_tgt_i   <= tgt;
    upd_kind_i  <= kind;
    upd_taken_i <= taken;
    @(posedge clk_i);
    upd_v_i     <= 1'b0;
  endtask

  task automatic expect_next(input logic [31:0] exp_pc);
    @(negedge clk_i);
    while (!fetch_v_o)
    begin
      @(negedge clk_i);
    end
    check_count++;
    assert (fetch_pc_o == exp_pc)
    else report_error("issued PC", exp_pc, fetch_pc_o);
  endtask

  // Steer fetch to start, then expect the PC issued after it
  task automatic check_follow(input logic [31:0] start, input logic [31:0] exp_pc);
    @(posedge clk_i);
    redirect_v_i  <= 1'b1;
    redirect_pc_i <= start;
    @(posedge clk_i);
    redirect_v_i  <= 1'b0;
    expect_next(start);
    expect_next(exp_pc);
  endtask

  task automatic end_test();
    test_count++;
    $display("Test %s done with %0d errors", test_name, error_count - test_err_base);
    test_err_base = error_count;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin : stimulus
    int          issued;
    logic [31:0] r;
    arst_n_i        = 1'b0;
    redirect_v_i    = 1'b0;
    redirect_pc_i   = '0;
    upd_v_i         = 1'b0;
    upd_pc_i        = '0;
    upd_tgt_i       = '0;
    upd_kind_i      = fe_pkg::KIND_BR;
    upd_taken_i     = 1'b0;
    credit_return_i = 1'b0;
    lfsr_q          = SEED;
    test_name       = "reset";
    error_count     = 0;
    check_count     = 0;
    test_err_base   = 0;
    cycle_count     = 0;
    test_count      = 0;
    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;

    // Four credits, then a stall until one comes back
    test_name = "sequential";
    issued    = 0;
    repeat (10)
    begin
      @(negedge clk_i);
      if (fetch_v_o)
      begin
        check_count++;
        assert (fetch_pc_o == fe_pkg::RESET_PC + 32'(4 * issued))
        else report_error("issued PC", fe_pkg::RESET_PC + 32'(4 * issued), fetch_pc_o);
        issued++;
      end
    end
    check_count++;
    assert (issued == fe_pkg::FETCH_CREDITS)
    else report_error("fetch count", 32'(fe_pkg::FETCH_CREDITS), 32'(issued));
    @(posedge clk_i);
    credit_return_i <= 1'b1;
    expect_next(fe_pkg::RESET_PC + 32'd16);
    end_test();

    test_name = "redirect";
    check_follow(32'h8000_0040, 32'h8000_0044);
    @(posedge clk_i);
    credit_return_i <= 1'b0;
    @(negedge clk_i);
    while (fetch_v_o)
    begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    redirect_v_i    <= 1'b1;
    redirect_pc_i   <= 32'h8000_0080;
    @(posedge clk_i);
    redirect_v_i    <= 1'b0;
    credit_return_i <= 1'b1;
    expect_next(32'h8000_0080);
    end_test();

    test_name = "jump";
    send_update(32'h8000_0104, 32'h8000_0400, fe_pkg::KIND_JAL, 1'b1);
    check_follow(32'h8000_0104, 32'h8000_0400);
    end_test();

    // Five taken branches elsewhere bring history to 6'h1f
    test_name = "branch";
    repeat (5) send_update(32'h8000_0100, 32'h8000_0000, fe_pkg::KIND_BR, 1'b1);
    send_update(32'h8000_0020, 32'h8000_0800, fe_pkg::KIND_BR, 1'b1);
    check_follow(32'h8000_0020, 32'h8000_0024);
    send_update(32'h8000_0020, 32'h8000_0800, fe_pkg::KIND_BR, 1'b1);
    check_follow(32'h8000_0020, 32'h8000_0800);
    end_test();

    test_name = "call_ret";
    send_update(32'h8000_0208, 32'h8000_0600, fe_pkg::KIND_CALL, 1'b1);
    send_update(32'h8000_0610, 32'h8000_0000, fe_pkg::KIND_RET, 1'b1);
    check_follow(32'h8000_0208, 32'h8000_0600);
    expect_next(32'h8000_0604);
    expect_next(32'h8000_0608);
    expect_next(32'h8000_060c);
    expect_next(32'h8000_0610);
    expect_next(32'h8000_020c);
    // Stack is empty again
    check_follow(32'h8000_0610, 32'h8000_0614);
    end_test();

    test_name = "random";
    repeat (500)
    begin
      @(posedge clk_i);
      r = rand_bits(3);
      redirect_v_i <= (r[2:0] == 3'd0);
      // Low two address bits are random, the DUT drops them
      r = rand_bits(8);
      redirect_pc_i <= {24'h80_0000, r[7:0]};
      r = rand_bits(2);
      upd_v_i <= (r[1:0] == 2'd0);
      r = rand_bits(6);
      upd_pc_i <= {24'h80_0000, r[5:0], 2'b00};
      r = rand_bits(8);
      upd_tgt_i <= {24'h80_0000, r[7:0]};
      r = rand_bits(2);
      upd_kind_i <= fe_pkg::branch_kind_e'(r[1:0]);
      r = rand_bits(1);
      upd_taken_i <= r[0];
      r = rand_bits(1);
      credit_return_i <= (m_credits != CREDIT_MAX) && r[0];
    end
    @(posedge clk_i);
    redirect_v_i    <= 1'b0;
    upd_v_i         <= 1'b0;
    credit_return_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    end_test();

    error_count = error_count + fe_top_i.pc_gen_i.pc_assert_i.fail_cnt;
    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
             error_count);
    if (error_count == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
verilog/fe_pkg.sv
verilog/fe_update_if.sv
verilog/fe_btb.sv
verilog/fe_bht.sv
verilog/fe_ras.sv
verilog/fe_pc_gen.sv
verilog/fe_top.sv
test/fe_assertions.sv
test/fe_tb.sv

// File: Makefile
# Verilator flow for the fetch front end

TOOL      := verilator
TOP       := fe_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := test passed

LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
